//--- stats_block.f
src/stats_pkg.sv
src/stats_counters.sv
src/status_access_ctrl.sv
src/status_reg_file.sv
src/stats_top.sv
tests/stats_props.sv
tests/stats_tb.sv

//--- run.sh
#!/bin/sh
# build and run the statistics block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module stats_tb -f stats_block.f -o stats_sim

status=0
./obj_dir/stats_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

//--- tests/stats_tb.sv
module stats_tb;
    import stats_pkg::*;

    // rough length of all directed tests together
    localparam int unsigned TEST_CYCLES    = 500;
    localparam int unsigned TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic                     clk_status = 1'b0;
    logic                     rst_n_i;
    logic                     in_valid_i;
    logic                     in_eop_i;
    logic                     out_valid_i;
    logic                     out_eop_i;
    logic                     out_ready_i;
    logic                     dma_update_i;
    logic                     cpu_meta_valid_i;
    logic                     cpu_meta_ready_i;
    cpu_action_e              cpu_meta_action_i;
    logic [STAT_W-1:0]        fill_dm2sm_i;
    logic [STAT_W-1:0]        fill_pg2nf_i;
    logic [STATUS_ADDR_W-1:0] status_addr_i;
    logic                     status_read_i;
    logic                     status_write_i;
    logic [STAT_W-1:0]        status_writedata_i;
    logic [STAT_W-1:0]        status_readdata_o;
    logic                     status_readdata_valid_o;

    // expected counts built up from the driven stimulus
    logic [STAT_W-1:0]        exp_in = '0;
    logic [STAT_W-1:0]        exp_out = '0;
    logic [STAT_W-1:0]        exp_dma = '0;
    logic [STAT_W-1:0]        exp_nomatch = '0;
    logic [STAT_W-1:0]        exp_match = '0;
    int unsigned              cycle_cnt = 0;

    stats_top dut_i (.*);

    always #50 clk_status = ~clk_status;

    // run limit
    always @(posedge clk_status) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, tests still running after %0d cycles", cycle_cnt);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_data(input logic [STAT_W-1:0] expected,
                                input logic [STAT_W-1:0] actual, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
            report_failure();
        end
    endtask

    task automatic compare_valid(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, expected %b, got %b", $time, what, expected, actual);
            report_failure();
        end
    endtask

    // select in the top bits and offset in the low bits
    function automatic logic [STATUS_ADDR_W-1:0] make_addr(input logic [SEL_W-1:0] sel,
                                                           input logic [REG_ADDR_W-1:0] offset);
        return {sel, {(STATUS_ADDR_W - SEL_W - REG_ADDR_W){1'b0}}, offset};
    endfunction

    // event and bus strobes low
    task automatic idle_events();
        in_valid_i       <= 1'b0;
        in_eop_i         <= 1'b0;
        out_valid_i      <= 1'b0;
        out_eop_i        <= 1'b0;
        out_ready_i      <= 1'b0;
        dma_update_i     <= 1'b0;
        cpu_meta_valid_i <= 1'b0;
        cpu_meta_ready_i <= 1'b0;
        status_read_i    <= 1'b0;
        status_write_i   <= 1'b0;
    endtask

    task automatic read_reg(input logic [SEL_W-1:0] sel, input logic [REG_ADDR_W-1:0] offset,
                            output logic [STAT_W-1:0] data);
        int waited = 0;
        @(posedge clk_status);
        status_addr_i <= make_addr(sel, offset);
        status_read_i <= 1'b1;
        @(posedge clk_status);
        status_read_i <= 1'b0;
        // sample between edges
        do begin
            @(negedge clk_status);
            waited++;
        end while (!status_readdata_valid_o && waited < 4);
        if (!status_readdata_valid_o) begin
            $display("no read response within 4 cycles for offset %0d", offset);
            report_failure();
        end
        data = status_readdata_o;
    endtask

    task automatic expect_read(input logic [SEL_W-1:0] sel, input logic [REG_ADDR_W-1:0] offset,
                               input logic [STAT_W-1:0] expected, input string what);
        logic [STAT_W-1:0] data;
        read_reg(sel, offset, data);
        compare_data(expected, data, what);
    endtask

    task automatic write_reg(input logic [SEL_W-1:0] sel, input logic [REG_ADDR_W-1:0] offset,
                             input logic [STAT_W-1:0] data);
        @(posedge clk_status);
        status_addr_i      <= make_addr(sel, offset);
        status_writedata_i <= data;
        status_write_i     <= 1'b1;
        @(posedge clk_status);
        status_write_i <= 1'b0;
    endtask

    // read outside the top space gets no valid
    task automatic expect_no_response(input logic [SEL_W-1:0] sel,
                                      input logic [REG_ADDR_W-1:0] offset);
        @(posedge clk_status);
        status_addr_i <= make_addr(sel, offset);
        status_read_i <= 1'b1;
        @(posedge clk_status);
        status_read_i <= 1'b0;
        repeat (4) begin
            @(negedge clk_status);
            compare_valid(1'b0, status_readdata_valid_o, "valid for a read outside the top space");
        end
    endtask

    task automatic reset_readback();
        for (int i = 0; i < 8; i++) begin
            expect_read(TOP_REG, i[REG_ADDR_W-1:0], '0, "register after reset");
        end
    endtask

    task automatic count_packets();
        logic [31:0] r;
        int beats = 20 + int'($urandom % 20);
        for (int i = 0; i < beats; i++) begin
            r = $urandom;
            @(posedge clk_status);
            in_valid_i  <= r[0];
            in_eop_i    <= r[1];
            out_valid_i <= r[2];
            out_eop_i   <= r[3];
            out_ready_i <= r[4];
            // only complete end-of-packet beats count
            exp_in  += STAT_W'(r[0] & r[1]);
            exp_out += STAT_W'(r[2] & r[3] & r[4]);
        end
        @(posedge clk_status);
        idle_events();
        expect_read(TOP_REG, REG_IN_PKT, exp_in, "ingress packet count");
        expect_read(TOP_REG, REG_OUT_PKT, exp_out, "egress packet count");
    endtask

    task automatic count_cpu_dma();
        logic [31:0] r;
        logic        meta_valid;
        logic        meta_ready;
        cpu_action_e act;
        for (int i = 0; i < 48; i++) begin
            r = $urandom;
            // first 16 items walk every action with ready low and high
            act        = (i < 16) ? cpu_action_e'(i[1:0]) : cpu_action_e'(r[1:0]);
            meta_valid = (i < 16) || r[2];
            meta_ready = (i < 16) ? i[2] : r[3];
            @(posedge clk_status);
            cpu_meta_valid_i  <= meta_valid;
            cpu_meta_ready_i  <= meta_ready;
            cpu_meta_action_i <= act;
            dma_update_i      <= r[4];
            // forward and drop are never counted
            exp_dma     += STAT_W'(r[4]);
            exp_nomatch += STAT_W'(meta_valid && meta_ready && act == ACTION_NOMATCH);
            exp_match   += STAT_W'(meta_valid && meta_ready && act == ACTION_MATCH);
        end
        @(posedge clk_status);
        idle_events();
        expect_read(TOP_REG, REG_DMA_PKT, exp_dma, "dma update count");
        expect_read(TOP_REG, REG_CPU_NOMATCH, exp_nomatch, "cpu no-match count");
        expect_read(TOP_REG, REG_CPU_MATCH, exp_match, "cpu match count");
    endtask

    task automatic track_fill_marks();
        logic [STAT_W-1:0] dm2sm;
        logic [STAT_W-1:0] pg2nf;
        logic [STAT_W-1:0] max_dm2sm = '0;
        logic [STAT_W-1:0] max_pg2nf = '0;
        for (int i = 0; i < 30; i++) begin
            dm2sm = $urandom;
            pg2nf = $urandom >> 8;
            @(posedge clk_status);
            fill_dm2sm_i <= dm2sm;
            fill_pg2nf_i <= pg2nf;
            max_dm2sm = (dm2sm > max_dm2sm) ? dm2sm : max_dm2sm;
            max_pg2nf = (pg2nf > max_pg2nf) ? pg2nf : max_pg2nf;
        end
        // marks must hold once the fifos drain
        @(posedge clk_status);
        fill_dm2sm_i <= '0;
        fill_pg2nf_i <= '0;
        expect_read(TOP_REG, REG_MAX_DM2SM, max_dm2sm, "dm2sm high-water mark");
        expect_read(TOP_REG, REG_MAX_PG2NF, max_pg2nf, "pg2nf high-water mark");
    endtask

    task automatic access_rules();
        logic [STAT_W-1:0] ctrl_val = $urandom | 32'h1;
        write_reg(TOP_REG, REG_CTRL, ctrl_val);
        expect_read(TOP_REG, REG_CTRL, ctrl_val, "control register readback");
        // top write elsewhere wipes control but leaves the counter
        write_reg(TOP_REG, REG_IN_PKT, ~ctrl_val);
        expect_read(TOP_REG, REG_CTRL, '0, "control after a write to another offset");
        expect_read(TOP_REG, REG_IN_PKT, exp_in, "packet count after a write to it");
        // other spaces are ignored
        write_reg(TOP_REG, REG_CTRL, ctrl_val);
        write_reg(2'd1, REG_IN_PKT, '0);
        write_reg(2'd3, REG_CTRL, ~ctrl_val);
        expect_read(TOP_REG, REG_CTRL, ctrl_val, "control after writes outside the top space");
        expect_no_response(2'd2, REG_CTRL);
        expect_read(TOP_REG, 8'd9, '0, "unmapped offset 9");
        // one-cycle valid two edges after the drive
        @(posedge clk_status);
        status_addr_i <= make_addr(TOP_REG, REG_CTRL);
        status_read_i <= 1'b1;
        @(posedge clk_status);
        status_read_i <= 1'b0;
        @(negedge clk_status);
        compare_valid(1'b0, status_readdata_valid_o, "valid one cycle after the read");
        @(negedge clk_status);
        compare_valid(1'b1, status_readdata_valid_o, "valid two cycles after the read");
        compare_data(ctrl_val, status_readdata_o, "control in the timed read");
        @(negedge clk_status);
        compare_valid(1'b0, status_readdata_valid_o, "valid three cycles after the read");
    endtask

    initial begin
        void'($urandom(32'h82d7cfdc));
        rst_n_i            <= 1'b0;
        status_addr_i      <= '0;
        status_writedata_i <= '0;
        cpu_meta_action_i  <= ACTION_NOMATCH;
        fill_dm2sm_i       <= '0;
        fill_pg2nf_i       <= '0;
        idle_events();
        repeat (4) @(posedge clk_status);
        rst_n_i <= 1'b1;
        reset_readback();
        count_packets();
        count_cpu_dma();
        track_fill_marks();
        access_rules();
        $display("sim passed");
        $finish;
    end

endmodule : stats_tb

//--- tests/stats_props.sv
module stats_props (
    input logic                                clk_status,
    input logic                                rst_n_i,
    input logic [stats_pkg::STATUS_ADDR_W-1:0] status_addr_i,
    input logic                                status_read_i,
    input logic                                status_readdata_valid_o
);
    import stats_pkg::*;

    // read strobe aimed at this block's space
    logic top_read;

    assign top_read = status_read_i && (status_addr_i[STATUS_ADDR_W-1 -: SEL_W] == TOP_REG);

    // every top-space read answered two edges later
    read_answered: assert property (@(posedge clk_status) disable iff (!rst_n_i)
        $past(top_read, 2) |-> status_readdata_valid_o)
        else $error("top-space read got no valid two cycles later");

    // valid only as the answer to such a read
    valid_has_read: assert property (@(posedge clk_status) disable iff (!rst_n_i)
        status_readdata_valid_o |-> $past(top_read, 2))
        else $error("read valid without a matching top-space read");

    // response register starts idle
    valid_low_after_reset: assert property (@(posedge clk_status)
        !rst_n_i |=> !status_readdata_valid_o)
        else $error("read valid high right after reset");

endmodule : stats_props

bind stats_top stats_props props_i (
    .clk_status              (clk_status),
    .rst_n_i                 (rst_n_i),
    .status_addr_i           (status_addr_i),
    .status_read_i           (status_read_i),
    .status_readdata_valid_o (status_readdata_valid_o)
);

//--- src/stats_top.sv
module stats_top (
    input  logic                                clk_status,
    input  logic                                rst_n_i,
    input  logic                                in_valid_i,
    input  logic                                in_eop_i,
    input  logic                                out_valid_i,
    input  logic                                out_eop_i,
    input  logic                                out_ready_i,
    input  logic                                dma_update_i,
    input  logic                                cpu_meta_valid_i,
    input  logic                                cpu_meta_ready_i,
    input  stats_pkg::cpu_action_e              cpu_meta_action_i,
    input  logic [stats_pkg::STAT_W-1:0]        fill_dm2sm_i,
    input  logic [stats_pkg::STAT_W-1:0]        fill_pg2nf_i,
    input  logic [stats_pkg::STATUS_ADDR_W-1:0] status_addr_i,
    input  logic                                status_read_i,
    input  logic                                status_write_i,
    input  logic [stats_pkg::STAT_W-1:0]        status_writedata_i,
    output logic [stats_pkg::STAT_W-1:0]        status_readdata_o,
    output logic                                status_readdata_valid_o
);
    import stats_pkg::*;

    // counter and mark values toward the read mux
    logic [STAT_W-1:0]     in_pkt_cnt;
    logic [STAT_W-1:0]     out_pkt_cnt;
    logic [STAT_W-1:0]     dma_pkt_cnt;
    logic [STAT_W-1:0]     cpu_nomatch_cnt;
    logic [STAT_W-1:0]     cpu_match_cnt;
    logic [STAT_W-1:0]     max_dm2sm;
    logic [STAT_W-1:0]     max_pg2nf;
    // decoded access, first pipeline stage
    access_op_e            access_op;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [STAT_W-1:0]     wr_data;

    stats_counters counters_i (
        .clk_status        (clk_status),
        .rst_n_i           (rst_n_i),
        .in_valid_i        (in_valid_i),
        .in_eop_i          (in_eop_i),
        .out_valid_i       (out_valid_i),
        .out_eop_i         (out_eop_i),
        .out_ready_i       (out_ready_i),
        .dma_update_i      (dma_update_i),
        .cpu_meta_valid_i  (cpu_meta_valid_i),
        .cpu_meta_ready_i  (cpu_meta_ready_i),
        .cpu_meta_action_i (cpu_meta_action_i),
        .fill_dm2sm_i      (fill_dm2sm_i),
        .fill_pg2nf_i      (fill_pg2nf_i),
        .in_pkt_cnt_o      (in_pkt_cnt),
        .out_pkt_cnt_o     (out_pkt_cnt),
        .dma_pkt_cnt_o     (dma_pkt_cnt),
        .cpu_nomatch_cnt_o (cpu_nomatch_cnt),
        .cpu_match_cnt_o   (cpu_match_cnt),
        .max_dm2sm_o       (max_dm2sm),
        .max_pg2nf_o       (max_pg2nf)
    );

    // bus capture and decode
    status_access_ctrl access_ctrl_i (
        .clk_status         (clk_status),
        .rst_n_i            (rst_n_i),
        .status_addr_i      (status_addr_i),
        .status_read_i      (status_read_i),
        .status_write_i     (status_write_i),
        .status_writedata_i (status_writedata_i),
        .access_op_o        (access_op),
        .reg_addr_o         (reg_addr),
        .wr_data_o          (wr_data)
    );

    // control register and read response, second stage
    status_reg_file reg_file_i (
        .clk_status              (clk_status),
        .rst_n_i                 (rst_n_i),
        .access_op_i             (access_op),
        .reg_addr_i              (reg_addr),
        .wr_data_i               (wr_data),
        .in_pkt_cnt_i            (in_pkt_cnt),
        .out_pkt_cnt_i           (out_pkt_cnt),
        .dma_pkt_cnt_i           (dma_pkt_cnt),
        .cpu_nomatch_cnt_i       (cpu_nomatch_cnt),
        .cpu_match_cnt_i         (cpu_match_cnt),
        .max_dm2sm_i             (max_dm2sm),
        .max_pg2nf_i             (max_pg2nf),
        .status_readdata_o       (status_readdata_o),
        .status_readdata_valid_o (status_readdata_valid_o)
    );

endmodule : stats_top

//--- src/status_reg_file.sv
module status_reg_file (
    input  logic                             clk_status,
    input  logic                             rst_n_i,
    input  stats_pkg::access_op_e            access_op_i,
    input  logic [stats_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [stats_pkg::STAT_W-1:0]     wr_data_i,
    input  logic [stats_pkg::STAT_W-1:0]     in_pkt_cnt_i,
    input  logic [stats_pkg::STAT_W-1:0]     out_pkt_cnt_i,
    input  logic [stats_pkg::STAT_W-1:0]     dma_pkt_cnt_i,
    input  logic [stats_pkg::STAT_W-1:0]     cpu_nomatch_cnt_i,
    input  logic [stats_pkg::STAT_W-1:0]     cpu_match_cnt_i,
    input  logic [stats_pkg::STAT_W-1:0]     max_dm2sm_i,
    input  logic [stats_pkg::STAT_W-1:0]     max_pg2nf_i,
    output logic [stats_pkg::STAT_W-1:0]     status_readdata_o,
    output logic                             status_readdata_valid_o
);
    import stats_pkg::*;

    // software control word
    logic [STAT_W-1:0] ctrl_q;
    // addressed value before the response register
    logic [STAT_W-1:0] rd_mux;

    // control register, load or clear from the decoder
    always_ff @(posedge clk_status) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else begin
            case (access_op_i)
                OP_WRITE_CTRL: ctrl_q <= wr_data_i;
                OP_CLEAR_CTRL: ctrl_q <= '0;
                default:       ctrl_q <= ctrl_q;
            endcase
        end
    end

    // read mux over the register map
    always_comb begin
        case (reg_addr_i)
            REG_CTRL:        rd_mux = ctrl_q;
            REG_IN_PKT:      rd_mux = in_pkt_cnt_i;
            REG_OUT_PKT:     rd_mux = out_pkt_cnt_i;
            REG_DMA_PKT:     rd_mux = dma_pkt_cnt_i;
            REG_CPU_NOMATCH: rd_mux = cpu_nomatch_cnt_i;
            REG_CPU_MATCH:   rd_mux = cpu_match_cnt_i;
            REG_MAX_DM2SM:   rd_mux = max_dm2sm_i;
            REG_MAX_PG2NF:   rd_mux = max_pg2nf_i;
            // unmapped offsets read as zero
            default:         rd_mux = '0;
        endcase
    end

    // single-cycle valid for each decoded read
    always_ff @(posedge clk_status) begin
        if (!rst_n_i) begin
            status_readdata_valid_o <= 1'b0;
        end else begin
            status_readdata_valid_o <= (access_op_i == OP_READ);
        end
    end

    // read data holds between responses
    always_ff @(posedge clk_status) begin
        if (access_op_i == OP_READ) begin
            status_readdata_o <= rd_mux;
        end
    end

endmodule : status_reg_file

//--- src/status_access_ctrl.sv
module status_access_ctrl (
    input  logic                                clk_status,
    input  logic                                rst_n_i,
    input  logic [stats_pkg::STATUS_ADDR_W-1:0] status_addr_i,
    input  logic                                status_read_i,
    input  logic                                status_write_i,
    input  logic [stats_pkg::STAT_W-1:0]        status_writedata_i,
    output stats_pkg::access_op_e               access_op_o,
    output logic [stats_pkg::REG_ADDR_W-1:0]    reg_addr_o,
    output logic [stats_pkg::STAT_W-1:0]        wr_data_o
);
    import stats_pkg::*;

    // bus strobes, registered once
    logic                  read_q;
    logic                  write_q;
    // address split into space select and register offset
    logic [SEL_W-1:0]      sel_q;
    logic [REG_ADDR_W-1:0] offset_q;
    logic [STAT_W-1:0]     wr_data_q;

    // strobes need a clean idle after reset
    always_ff @(posedge clk_status) begin
        if (!rst_n_i) begin
            read_q  <= 1'b0;
            write_q <= 1'b0;
        end else begin
            read_q  <= status_read_i;
            write_q <= status_write_i;
        end
    end

    // address and write data only matter alongside a strobe
    always_ff @(posedge clk_status) begin
        sel_q     <= status_addr_i[STATUS_ADDR_W-1 -: SEL_W];
        offset_q  <= status_addr_i[REG_ADDR_W-1:0];
        wr_data_q <= status_writedata_i;
    end

    // one opcode per cycle from the registered bus
    always_comb begin
        access_op_o = OP_NONE;
        // other spaces belong to other blocks, no response from here
        if (sel_q == TOP_REG) begin
            // read takes priority over a write in the same cycle
            if (read_q) begin
                access_op_o = OP_READ;
            end else if (write_q) begin
                // any other top offset wipes the control register
                access_op_o = (offset_q == REG_CTRL) ? OP_WRITE_CTRL : OP_CLEAR_CTRL;
            end
        end
    end

    assign reg_addr_o = offset_q;
    assign wr_data_o  = wr_data_q;

endmodule : status_access_ctrl

//--- src/stats_counters.sv
module stats_counters (
    input  logic                         clk_status,
    input  logic                         rst_n_i,
    input  logic                         in_valid_i,
    input  logic                         in_eop_i,
    input  logic                         out_valid_i,
    input  logic                         out_eop_i,
    input  logic                         out_ready_i,
    input  logic                         dma_update_i,
    input  logic                         cpu_meta_valid_i,
    input  logic                         cpu_meta_ready_i,
    input  stats_pkg::cpu_action_e       cpu_meta_action_i,
    input  logic [stats_pkg::STAT_W-1:0] fill_dm2sm_i,
    input  logic [stats_pkg::STAT_W-1:0] fill_pg2nf_i,
    output logic [stats_pkg::STAT_W-1:0] in_pkt_cnt_o,
    output logic [stats_pkg::STAT_W-1:0] out_pkt_cnt_o,
    output logic [stats_pkg::STAT_W-1:0] dma_pkt_cnt_o,
    output logic [stats_pkg::STAT_W-1:0] cpu_nomatch_cnt_o,
    output logic [stats_pkg::STAT_W-1:0] cpu_match_cnt_o,
    output logic [stats_pkg::STAT_W-1:0] max_dm2sm_o,
    output logic [stats_pkg::STAT_W-1:0] max_pg2nf_o
);
    import stats_pkg::*;

    // qualified events, one per counter
    logic in_pkt_hit;
    logic out_pkt_hit;
    logic cpu_accept;
    logic cpu_nomatch_hit;
    logic cpu_match_hit;

    // a packet is counted on its last beat
    assign in_pkt_hit  = in_valid_i & in_eop_i;
    // egress needs the sink to take the beat too
    assign out_pkt_hit = out_valid_i & out_eop_i & out_ready_i;

    // metadata item handed over to the cpu
    assign cpu_accept      = cpu_meta_valid_i & cpu_meta_ready_i;
    // forward and drop actions fall through uncounted
    assign cpu_nomatch_hit = cpu_accept & (cpu_meta_action_i == ACTION_NOMATCH);
    assign cpu_match_hit   = cpu_accept & (cpu_meta_action_i == ACTION_MATCH);

    // ethernet port counters
    always_ff @(posedge clk_status) begin
        if (!rst_n_i) begin
            in_pkt_cnt_o  <= '0;
            out_pkt_cnt_o <= '0;
        end else begin
            // free running, wraps at 2^32
            if (in_pkt_hit) begin
                in_pkt_cnt_o <= in_pkt_cnt_o + 1'b1;
            end
            if (out_pkt_hit) begin
                out_pkt_cnt_o <= out_pkt_cnt_o + 1'b1;
            end
        end
    end

    // dma ring updates and cpu metadata counters
    always_ff @(posedge clk_status) begin
        if (!rst_n_i) begin
            dma_pkt_cnt_o     <= '0;
            cpu_nomatch_cnt_o <= '0;
            cpu_match_cnt_o   <= '0;
        end else begin
            // one pulse per ring-buffer update
            if (dma_update_i) begin
                dma_pkt_cnt_o <= dma_pkt_cnt_o + 1'b1;
            end
            if (cpu_nomatch_hit) begin
                cpu_nomatch_cnt_o <= cpu_nomatch_cnt_o + 1'b1;
            end
            if (cpu_match_hit) begin
                cpu_match_cnt_o <= cpu_match_cnt_o + 1'b1;
            end
        end
    end

    // high-water marks of the two channel fifos
    always_ff @(posedge clk_status) begin
        if (!rst_n_i) begin
            max_dm2sm_o <= '0;
            max_pg2nf_o <= '0;
        end else begin
            // only ever moves up until the next reset
            if (fill_dm2sm_i > max_dm2sm_o) begin
                max_dm2sm_o <= fill_dm2sm_i;
            end
            if (fill_pg2nf_i > max_pg2nf_o) begin
                max_pg2nf_o <= fill_pg2nf_i;
            end
        end
    end

endmodule : stats_counters

//--- src/stats_pkg.sv
package stats_pkg;

    // counters, fill levels and status bus data
    localparam int unsigned STAT_W = 32;

    // status bus address
    localparam int unsigned STATUS_ADDR_W = 30;

    // register offset sits in the low address bits
    localparam int unsigned REG_ADDR_W = 8;

    // space select sits in the top address bits
    localparam int unsigned SEL_W = 2;

    // select value of this block's register space
    localparam logic [SEL_W-1:0] TOP_REG = 2'd0;

    // register map, offsets inside the top space
    localparam logic [REG_ADDR_W-1:0] REG_CTRL        = 8'd0;
    localparam logic [REG_ADDR_W-1:0] REG_IN_PKT      = 8'd1;
    localparam logic [REG_ADDR_W-1:0] REG_OUT_PKT     = 8'd2;
    localparam logic [REG_ADDR_W-1:0] REG_DMA_PKT     = 8'd3;
    localparam logic [REG_ADDR_W-1:0] REG_CPU_NOMATCH = 8'd4;
    localparam logic [REG_ADDR_W-1:0] REG_CPU_MATCH   = 8'd5;
    localparam logic [REG_ADDR_W-1:0] REG_MAX_DM2SM   = 8'd6;
    localparam logic [REG_ADDR_W-1:0] REG_MAX_PG2NF   = 8'd7;

    // action field of a cpu metadata item
    localparam int unsigned ACTION_W = 2;

    typedef enum logic [ACTION_W-1:0] {
        ACTION_NOMATCH = 2'd0,
        ACTION_MATCH   = 2'd1,
        ACTION_FORWARD = 2'd2,
        ACTION_DROP    = 2'd3
    } cpu_action_e;

    // one decoded status bus access per cycle
    typedef enum logic [1:0] {
        OP_NONE       = 2'd0,
        OP_READ       = 2'd1,
        OP_WRITE_CTRL = 2'd2,
        OP_CLEAR_CTRL = 2'd3
    } access_op_e;

endpackage : stats_pkg
